// ==== design/axil_pkg.sv ====
// AXI4-Lite slave side types for the UART register port
// no IDs, no burst support; bresp and rresp carry OKAY only
// word addressed through a 5-bit byte address
`default_nettype none

package axil_pkg;

  localparam int unsigned AXIL_ADDR_W = 5;
  localparam int unsigned AXIL_DATA_W = 32;

  typedef logic [1:0] axil_resp_t;

  localparam axil_resp_t RESP_OKAY = 2'b00;

  // master to slave
  typedef struct packed {
    logic [AXIL_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic [AXIL_DATA_W-1:0]   wdata;
    logic [AXIL_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     bready;
    logic [AXIL_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    axil_resp_t             bresp;
    logic                   bvalid;
    logic                   arready;
    logic [AXIL_DATA_W-1:0] rdata;
    axil_resp_t             rresp;
    logic                   rvalid;
  } axil_rsp_t;

endpackage

`default_nettype wire

// ==== design/byte_fifo.sv ====
// byte FIFO, FIFO_DEPTH entries, head visible on data_o
// data_o is only meaningful while empty_o is low
`default_nettype none
`timescale 1ns/100ps

module byte_fifo import uart_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   push_i,
  input  wire                   pull_i,
  input  wire  [7:0]            data_i,
  output logic [7:0]            data_o,
  output logic                  full_o,
  output logic                  empty_o,
  output logic [FIFO_CNT_W-1:0] count_o
);

  logic [7:0]            mem [FIFO_DEPTH];
  logic [FIFO_CNT_W-2:0] wr_ptr, rd_ptr;  // wrap on their own
  logic                  wr_en, rd_en;

  assign full_o  = (count_o == FIFO_CNT_W'(FIFO_DEPTH));
  assign empty_o = (count_o == '0);
  assign wr_en   = push_i && !full_o;
  assign rd_en   = pull_i && !empty_o;
  assign data_o  = mem[rd_ptr];  // first word view

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: ;  // both or neither
      endcase
    end
  end

  // producers and consumers check the flags before acting
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    !(push_i && full_o));
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    !(pull_i && empty_o));

endmodule

`default_nettype wire

// ==== design/uart_axil_top.sv ====
// UART peripheral with an AXI4-Lite register port
// one 16 byte FIFO per direction, irq_o is level and registered
// divisor below 2 is not supported
`default_nettype none
`timescale 1ns/100ps

module uart_axil_top import axil_pkg::*, uart_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  axil_req_t  bus_i,
  output axil_rsp_t  bus_o,
  input  wire        uart_rx_i,
  output logic       uart_tx_o,
  output logic       irq_o
);

  line_cfg_t  line_cfg;
  logic       tx_push, tx_pull, tx_full, tx_empty, tx_busy;
  logic [7:0] tx_wr_byte, tx_head;
  logic       rx_push, rx_pull, rx_full, rx_empty;
  logic [7:0] rx_wr_byte, rx_head;

  uart_regs i_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus_i      (bus_i),
    .bus_o      (bus_o),
    .line_cfg_o (line_cfg),
    .irq_o      (irq_o),
    .tx_push_o  (tx_push),
    .tx_data_o  (tx_wr_byte),
    .tx_full_i  (tx_full),
    .tx_empty_i (tx_empty),
    .rx_pull_o  (rx_pull),
    .rx_data_i  (rx_head),
    .rx_empty_i (rx_empty),
    .tx_busy_i  (tx_busy)
  );

  byte_fifo i_tx_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (tx_push),
    .pull_i  (tx_pull),
    .data_i  (tx_wr_byte),
    .data_o  (tx_head),
    .full_o  (tx_full),
    .empty_o (tx_empty),
    .count_o ()           // fill level not needed here
  );

  byte_fifo i_rx_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (rx_push),
    .pull_i  (rx_pull),
    .data_i  (rx_wr_byte),
    .data_o  (rx_head),
    .full_o  (rx_full),
    .empty_o (rx_empty),
    .count_o ()
  );

  uart_tx i_tx (
    .clk          (clk),
    .rst_n        (rst_n),
    .line_cfg_i   (line_cfg),
    .fifo_empty_i (tx_empty),
    .fifo_data_i  (tx_head),
    .fifo_pull_o  (tx_pull),
    .tx_o         (uart_tx_o),
    .busy_o       (tx_busy)
  );

  uart_rx i_rx (
    .clk         (clk),
    .rst_n       (rst_n),
    .line_cfg_i  (line_cfg),
    .rx_i        (uart_rx_i),
    .fifo_full_i (rx_full),
    .push_o      (rx_push),
    .data_o      (rx_wr_byte)
  );

endmodule

`default_nettype wire

// ==== design/uart_pkg.sv ====
// UART register map, line control layout and sizing
// word offsets index addr[4:2]; FIFO_DEPTH must be a power of two
// DIV_RESET assumes a 50 MHz clock for 115200 baud
`default_nettype none

package uart_pkg;

  // word offsets
  localparam logic [2:0] REG_DATA = 3'd0;  // rx read / tx write
  localparam logic [2:0] REG_IER  = 3'd1;
  localparam logic [2:0] REG_DIV  = 3'd2;  // needs DLAB
  localparam logic [2:0] REG_LCR  = 3'd3;
  localparam logic [2:0] REG_LSR  = 3'd5;  // read only

  // line status bit positions
  localparam int unsigned LSR_DR   = 0;
  localparam int unsigned LSR_THRE = 5;
  localparam int unsigned LSR_TEMT = 6;

  localparam int unsigned DIV_W     = 16;
  localparam logic [DIV_W-1:0] DIV_RESET = 16'd434;

  localparam int unsigned FIFO_DEPTH = 16;
  localparam int unsigned FIFO_CNT_W = 5;  // holds 0..FIFO_DEPTH

  typedef struct packed {
    logic       dlab;         // bit 7
    logic [1:0] rsvd_hi;
    logic       parity_even;  // 0 = odd
    logic       parity_en;
    logic [1:0] rsvd_lo;
    logic       stop2;        // bit 0
  } lcr_t;

  // what the serial side needs
  typedef struct packed {
    logic             stop2;
    logic             parity_en;
    logic             parity_even;
    logic [DIV_W-1:0] divisor;  // clocks per bit
  } line_cfg_t;

endpackage

`default_nettype wire

// ==== design/uart_regs.sv ====
// AXI4-Lite register block, separate write and read FSMs
// unmapped or DLAB-blocked accesses complete with OKAY, reads give 0
// a data write stalls (no ready) while the tx FIFO is full
// wstrb is ignored, every write is a full word write
`default_nettype none
`timescale 1ns/100ps

module uart_regs import axil_pkg::*, uart_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  axil_req_t  bus_i,
  output axil_rsp_t  bus_o,
  output line_cfg_t  line_cfg_o,
  output logic       irq_o,
  output logic       tx_push_o,
  output logic [7:0] tx_data_o,
  input  wire        tx_full_i,
  input  wire        tx_empty_i,
  output logic       rx_pull_o,
  input  wire  [7:0] rx_data_i,
  input  wire        rx_empty_i,
  input  wire        tx_busy_i
);

  typedef enum logic {ST_IDLE, ST_ACK} bus_st_e;

  bus_st_e                wr_st, rd_st;
  logic                   wr_ack_q, bvalid_q;
  logic                   arready_q, rvalid_q;
  logic [AXIL_DATA_W-1:0] rdata_q, rd_value, lsr;
  logic [2:0]             wr_word, rd_word;
  logic                   wr_go, rd_pull;
  lcr_t                   lcr_q;
  logic                   ier_q;
  logic [DIV_W-1:0]       div_pend_q, div_q;

  assign wr_word = bus_i.awaddr[AXIL_ADDR_W-1:2];
  assign rd_word = bus_i.araddr[AXIL_ADDR_W-1:2];

  // hold off a data write until the tx FIFO has room
  assign wr_go = bus_i.awvalid && bus_i.wvalid &&
                 !(wr_word == REG_DATA && !lcr_q.dlab && tx_full_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_st      <= ST_IDLE;
      wr_ack_q   <= 1'b0;
      bvalid_q   <= 1'b0;
      tx_push_o  <= 1'b0;
      lcr_q      <= '0;
      ier_q      <= 1'b0;
      div_pend_q <= DIV_RESET;
      div_q      <= DIV_RESET;
    end else begin
      wr_ack_q  <= 1'b0;  // ready is a single cycle
      tx_push_o <= 1'b0;
      case (wr_st)
        ST_IDLE: if (wr_go) begin
          wr_st    <= ST_ACK;
          wr_ack_q <= 1'b1;
          bvalid_q <= 1'b1;
          case (wr_word)
            REG_DATA: tx_push_o <= !lcr_q.dlab;
            REG_IER:  if (!lcr_q.dlab) ier_q <= bus_i.wdata[0];
            REG_DIV:  if (lcr_q.dlab) div_pend_q <= bus_i.wdata[DIV_W-1:0];
            REG_LCR:  lcr_q <= lcr_t'(bus_i.wdata[7:0]);
            default: ;  // accepted and dropped
          endcase
        end
        ST_ACK: if (bus_i.bready) begin
          bvalid_q <= 1'b0;
          wr_st    <= ST_IDLE;
          div_q    <= div_pend_q;  // new divisor only once the write is done
        end
        default: wr_st <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_st == ST_IDLE && wr_go) tx_data_o <= bus_i.wdata[7:0];
  end

  always_comb begin
    lsr           = '0;
    lsr[LSR_DR]   = !rx_empty_i;
    lsr[LSR_THRE] = tx_empty_i;
    lsr[LSR_TEMT] = tx_empty_i && !tx_busy_i;  // last stop bit gone
  end

  always_comb begin
    rd_value = '0;
    rd_pull  = 1'b0;
    case (rd_word)
      REG_DATA: if (!lcr_q.dlab && !rx_empty_i) begin
        rd_value[7:0] = rx_data_i;
        rd_pull       = 1'b1;
      end
      REG_IER:  rd_value[0] = ier_q && !lcr_q.dlab;
      REG_DIV:  if (lcr_q.dlab) rd_value[DIV_W-1:0] = div_q;
      REG_LCR:  rd_value[7:0] = lcr_q;
      REG_LSR:  rd_value = lsr;
      default: ;  // unmapped reads as zero
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_st     <= ST_IDLE;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rx_pull_o <= 1'b0;
    end else begin
      arready_q <= 1'b0;
      rx_pull_o <= 1'b0;
      case (rd_st)
        ST_IDLE: if (bus_i.arvalid) begin
          rd_st     <= ST_ACK;
          arready_q <= 1'b1;
          rvalid_q  <= 1'b1;
          rx_pull_o <= rd_pull;  // pop after head is captured
        end
        ST_ACK: if (bus_i.rready) begin
          rvalid_q <= 1'b0;
          rd_st    <= ST_IDLE;
        end
        default: rd_st <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_st == ST_IDLE && bus_i.arvalid) rdata_q <= rd_value;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) irq_o <= 1'b0;
    else        irq_o <= ier_q && !rx_empty_i;
  end

  always_comb begin
    bus_o.awready = wr_ack_q;
    bus_o.wready  = wr_ack_q;
    bus_o.bresp   = RESP_OKAY;
    bus_o.bvalid  = bvalid_q;
    bus_o.arready = arready_q;
    bus_o.rdata   = rdata_q;
    bus_o.rresp   = RESP_OKAY;
    bus_o.rvalid  = rvalid_q;
  end

  assign line_cfg_o.stop2       = lcr_q.stop2;
  assign line_cfg_o.parity_en   = lcr_q.parity_en;
  assign line_cfg_o.parity_even = lcr_q.parity_even;
  assign line_cfg_o.divisor     = div_q;

  // a response stays up until the master takes it
  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus_o.bvalid && !bus_i.bready |=> bus_o.bvalid);
  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus_o.rvalid && !bus_i.rready |=> bus_o.rvalid);

endmodule

`default_nettype wire

// ==== design/uart_rx.sv ====
// UART receiver with two-flop input synchronizer
// samples each bit in its middle, drops frames with a parity or stop error
// only the first stop bit is checked, a second one looks like idle line
`default_nettype none
`timescale 1ns/100ps

module uart_rx import uart_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  line_cfg_t  line_cfg_i,
  input  wire        rx_i,
  input  wire        fifo_full_i,
  output logic       push_o,
  output logic [7:0] data_o
);

  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_st_e;

  rx_st_e           state_q;
  logic             rx_meta, rx_sync, rx_prev;
  logic             rx_fall, mid_hit, bit_hit;
  logic [DIV_W-1:0] baud_cnt;
  logic [2:0]       bit_idx;
  logic             par_err;
  line_cfg_t        cfg_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign rx_fall = rx_prev && !rx_sync;
  assign mid_hit = (baud_cnt == (cfg_q.divisor >> 1) - DIV_W'(1));  // half a bit
  assign bit_hit = (baud_cnt == cfg_q.divisor - DIV_W'(1));

  always_ff @(posedge clk) begin
    if (state_q == RX_IDLE && rx_fall) cfg_q <= line_cfg_i;
    if (state_q == RX_DATA && bit_hit) data_o <= {rx_sync, data_o[7:1]};  // lsb first
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      par_err  <= 1'b0;
      push_o   <= 1'b0;
    end else begin
      push_o   <= 1'b0;
      baud_cnt <= baud_cnt + 1'b1;
      case (state_q)
        RX_IDLE: begin
          baud_cnt <= '0;
          if (rx_fall) begin
            state_q <= RX_START;
            par_err <= 1'b0;
          end
        end
        RX_START: if (mid_hit) begin
          baud_cnt <= '0;
          bit_idx  <= '0;
          state_q  <= rx_sync ? RX_IDLE : RX_DATA;  // glitch if high again
        end
        RX_DATA: if (bit_hit) begin
          baud_cnt <= '0;
          bit_idx  <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) state_q <= cfg_q.parity_en ? RX_PARITY : RX_STOP;
        end
        RX_PARITY: if (bit_hit) begin
          baud_cnt <= '0;
          par_err  <= (^data_o) ^ rx_sync ^ !cfg_q.parity_even;
          state_q  <= RX_STOP;
        end
        RX_STOP: if (bit_hit) begin
          state_q <= RX_IDLE;
          push_o  <= rx_sync && !par_err && !fifo_full_i;  // full means lost
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/uart_tx.sv ====
// UART transmitter, 8 data bits LSB first
// optional parity, one or two stop bits, divisor clocks per bit
// line settings are taken when a byte is pulled from the FIFO
`default_nettype none
`timescale 1ns/100ps

module uart_tx import uart_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  line_cfg_t  line_cfg_i,
  input  wire        fifo_empty_i,
  input  wire  [7:0] fifo_data_i,
  output logic       fifo_pull_o,
  output logic       tx_o,
  output logic       busy_o
);

  typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_st_e;

  tx_st_e           state_q;
  logic [DIV_W-1:0] baud_cnt;
  logic [2:0]       bit_idx;
  logic             stop_second;
  logic             baud_end, par_bit;
  logic [7:0]       data_q;
  line_cfg_t        cfg_q;

  assign fifo_pull_o = (state_q == TX_IDLE) && !fifo_empty_i;
  assign busy_o      = (state_q != TX_IDLE);
  assign baud_end    = (baud_cnt == cfg_q.divisor - DIV_W'(1));
  assign par_bit     = (^data_q) ^ !cfg_q.parity_even;

  always_ff @(posedge clk) begin
    if (fifo_pull_o) begin
      data_q <= fifo_data_i;
      cfg_q  <= line_cfg_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= TX_IDLE;
      tx_o        <= 1'b1;  // line idles high
      baud_cnt    <= '0;
      bit_idx     <= '0;
      stop_second <= 1'b0;
    end else begin
      if (state_q == TX_IDLE || baud_end) baud_cnt <= '0;
      else                                baud_cnt <= baud_cnt + 1'b1;
      case (state_q)
        TX_IDLE: if (fifo_pull_o) begin
          state_q <= TX_START;
          tx_o    <= 1'b0;
        end
        TX_START: if (baud_end) begin
          state_q <= TX_DATA;
          bit_idx <= '0;
          tx_o    <= data_q[0];
        end
        TX_DATA: if (baud_end) begin
          if (bit_idx != 3'd7) begin
            bit_idx <= bit_idx + 1'b1;
            tx_o    <= data_q[bit_idx + 3'd1];
          end else if (cfg_q.parity_en) begin
            state_q <= TX_PARITY;
            tx_o    <= par_bit;
          end else begin
            state_q     <= TX_STOP;
            stop_second <= 1'b0;
            tx_o        <= 1'b1;
          end
        end
        TX_PARITY: if (baud_end) begin
          state_q     <= TX_STOP;
          stop_second <= 1'b0;
          tx_o        <= 1'b1;
        end
        TX_STOP: if (baud_end) begin
          if (cfg_q.stop2 && !stop_second) stop_second <= 1'b1;
          else                             state_q <= TX_IDLE;
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
design/axil_pkg.sv
design/uart_pkg.sv
design/byte_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/uart_axil_top.sv
sim/uart_line_checker.sv
sim/tb_uart_axil.sv

// ==== run.sh ====
#!/bin/sh
# build and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_uart_axil \
  -f list.f \
  -o tb_uart_axil
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_uart_axil > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" sim.log; then
  exit 0
fi
exit 1

// ==== sim/tb_uart_axil.sv ====
// testbench for the UART peripheral, tx looped back to rx through a mux
// bus inputs change 10 ns after the rising edge, 100 ns clock
// bready and rready come one cycle after the response is raised
// all waits on the DUT are bounded by the watchdog
`default_nettype none
`timescale 1ns/100ps

module tb_uart_axil import axil_pkg::*, uart_pkg::*;;

  localparam int  TEST_DIV    = 8;
  localparam int  FRAME_TOTAL = 40;
  localparam real WATCHDOG_NS = FRAME_TOTAL * 12.0 * TEST_DIV * 100.0 * 2.0 + 100000.0;
  localparam logic [31:0] LSR_IDLE = (32'd1 << LSR_THRE) | (32'd1 << LSR_TEMT);

  logic             clk = 1'b0;
  logic             rst_n = 1'b0;
  axil_req_t        bus_req;
  axil_rsp_t        bus_rsp;
  logic             uart_tx, uart_rx, irq;
  logic             loop_sel = 1'b0;  // 1 = testbench drives rx
  logic             own_line = 1'b1;
  logic [DIV_W-1:0] cur_div = DIV_RESET;
  logic [31:0]      lfsr_q = 32'hc601_de24;
  int               tb_errors = 0;
  int               tests_failed = 0;
  int               test_start_err;

  assign uart_rx = loop_sel ? own_line : uart_tx;

  always #50 clk = ~clk;

  uart_axil_top i_dut (
    .clk(clk), .rst_n(rst_n), .bus_i(bus_req), .bus_o(bus_rsp),
    .uart_rx_i(uart_rx), .uart_tx_o(uart_tx), .irq_o(irq)
  );

  uart_line_checker i_chk (
    .clk(clk), .rst_n(rst_n), .tx_i(uart_tx), .irq_i(irq), .divisor_i(cur_div),
    .bus_i(bus_req), .bus_o(bus_rsp)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // start, data lsb first, optional parity, stop bits; bit 0 goes out first
  function automatic logic [11:0] expected_frame(input logic [7:0] d, input lcr_t lcr);
    logic [11:0] f;
    f = 12'hfff;
    f[0] = 1'b0;
    f[8:1] = d;
    if (lcr.parity_en) f[9] = lcr.parity_even ? ^d : ~^d;
    return f;
  endfunction

  function automatic int frame_len(input lcr_t lcr);
    return 10 + int'(lcr.parity_en) + int'(lcr.stop2);
  endfunction

  function automatic int total_errors();
    return tb_errors + i_chk.err_count;
  endfunction

  task automatic next_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      b[i]   = lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  task automatic bus_write(input logic [2:0] word, input logic [31:0] data);
    @(posedge clk); #10;
    bus_req.awaddr  = {word, 2'b00};
    bus_req.wdata   = data;
    bus_req.wstrb   = 4'hf;
    bus_req.awvalid = 1'b1;
    bus_req.wvalid  = 1'b1;
    do begin
      @(posedge clk); #1;
    end while (!bus_rsp.awready);
    @(posedge clk); #10;  // handshake edge passed
    bus_req.awvalid = 1'b0;
    bus_req.wvalid  = 1'b0;
    @(posedge clk); #10;  // response waits a cycle for bready
    bus_req.bready  = 1'b1;
    @(posedge clk); #10;
    bus_req.bready  = 1'b0;
  endtask

  task automatic bus_read(input logic [2:0] word, output logic [31:0] data);
    @(posedge clk); #10;
    bus_req.araddr  = {word, 2'b00};
    bus_req.arvalid = 1'b1;
    do begin
      @(posedge clk); #1;
    end while (!bus_rsp.rvalid);
    data = bus_rsp.rdata;
    @(posedge clk); #10;
    bus_req.arvalid = 1'b0;
    @(posedge clk); #10;  // response waits a cycle for rready
    bus_req.rready  = 1'b1;
    @(posedge clk); #10;
    bus_req.rready  = 1'b0;
  endtask

  task automatic read_expect(input logic [2:0] word, input logic [31:0] exp);
    logic [31:0] d;
    i_chk.add_read(exp, 32'hffff_ffff);
    bus_read(word, d);
  endtask

  task automatic read_poll(input logic [2:0] word, output logic [31:0] d);
    i_chk.add_read(32'h0, 32'h0);
    bus_read(word, d);
  endtask

  task automatic wait_lsr(input int bit_pos, input logic val);
    logic [31:0] d;
    do read_poll(REG_LSR, d); while (d[bit_pos] !== val);
  endtask

  task automatic drain_rx();
    logic [31:0] d;
    read_poll(REG_LSR, d);
    while (d[LSR_DR]) begin
      read_poll(REG_DATA, d);
      read_poll(REG_LSR, d);
    end
  endtask

  task automatic send_byte(input logic [7:0] b, input lcr_t lcr);
    i_chk.add_frame(expected_frame(b, lcr), frame_len(lcr));
    bus_write(REG_DATA, {24'h0, b});
  endtask

  task automatic drive_frame(input logic [11:0] bits, input int len);
    for (int i = 0; i < len; i++) begin
      own_line = bits[i];
      repeat (int'(cur_div)) @(posedge clk);
      #10;
    end
    own_line = 1'b1;
    repeat (2 * int'(cur_div)) @(posedge clk);
    #10;
  endtask

  task automatic test_done(input int num, input string name);
    int n;
    n = total_errors() - test_start_err;
    if (n != 0) tests_failed++;
    $display("test %0d %s: %s (%0d errors)", num, name, n == 0 ? "ok" : "failed", n);
    test_start_err = total_errors();
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the tests did not finish in time");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    logic [7:0]  b;
    logic [7:0]  sent[$];
    logic [11:0] bad;
    lcr_t        lcr;
    lcr_t        modes[4];
    bus_req = '0;
    modes[0] = 8'h00;
    modes[1] = 8'h01;
    modes[2] = 8'h08;
    modes[3] = 8'h19;
    repeat (5) @(posedge clk);
    #10 rst_n = 1'b1;
    test_start_err = 0;

    read_expect(REG_LSR, LSR_IDLE);
    i_chk.check_irq(1'b0, "after reset");
    read_expect(3'd4, 32'h0);
    read_expect(3'd7, 32'h0);
    test_done(1, "reset values");

    bus_write(REG_LCR, 32'h80);
    bus_write(REG_DIV, TEST_DIV);
    bus_write(REG_LCR, 32'h00);
    cur_div = DIV_W'(TEST_DIV);
    for (int m = 0; m < 4; m++) begin
      bus_write(REG_LCR, {24'h0, modes[m]});
      for (int k = 0; k < 3; k++) begin
        next_byte(b);
        send_byte(b, modes[m]);
      end
      wait_lsr(LSR_TEMT, 1'b1);
    end
    drain_rx();
    test_done(2, "divisor and format");

    lcr = 8'h08;
    bus_write(REG_LCR, {24'h0, lcr});
    for (int k = 0; k < 4; k++) begin
      next_byte(b);
      sent.push_back(b);
      send_byte(b, lcr);
    end
    wait_lsr(LSR_TEMT, 1'b1);
    repeat (4 * TEST_DIV) @(posedge clk);
    read_expect(REG_LSR, LSR_IDLE | 32'h1);
    while (sent.size() != 0) read_expect(REG_DATA, {24'h0, sent.pop_front()});
    read_expect(REG_LSR, LSR_IDLE);
    read_expect(REG_DATA, 32'h0);
    test_done(3, "loopback");

    bus_write(REG_IER, 32'h0);
    next_byte(b);
    send_byte(b, lcr);
    wait_lsr(LSR_TEMT, 1'b1);
    repeat (4 * TEST_DIV) @(posedge clk);
    i_chk.check_irq(1'b0, "IER clear with data waiting");
    bus_write(REG_IER, 32'h1);
    repeat (3) @(posedge clk);
    i_chk.check_irq(1'b1, "IER set with data waiting");
    read_expect(REG_DATA, {24'h0, b});
    repeat (3) @(posedge clk);
    i_chk.check_irq(1'b0, "rx FIFO drained");
    bus_write(REG_IER, 32'h0);
    test_done(4, "interrupt");

    for (int k = 0; k < 20; k++) begin
      next_byte(b);
      send_byte(b, lcr);
    end
    wait_lsr(LSR_TEMT, 1'b1);
    repeat (4 * TEST_DIV) @(posedge clk);
    drain_rx();
    test_done(5, "back-pressure");

    lcr = 8'h18;
    bus_write(REG_LCR, {24'h0, lcr});
    loop_sel = 1'b1;
    next_byte(b);
    bad = expected_frame(b, lcr);
    bad[9] = ~bad[9];  // wrong parity
    drive_frame(bad, frame_len(lcr));
    next_byte(b);
    drive_frame(expected_frame(b, lcr), frame_len(lcr));
    loop_sel = 1'b0;
    read_expect(REG_DATA, {24'h0, b});
    read_expect(REG_LSR, LSR_IDLE);
    test_done(6, "frame filtering");

    repeat (2 * TEST_DIV) @(posedge clk);
    if (i_chk.pending() != 0) begin
      tb_errors++;
      $display("%0d expected frames or reads never completed", i_chk.pending());
    end
    $display("summary: 6 tests, %0d failed, %0d errors", tests_failed, total_errors());
    if (total_errors() == 0) $display("TB PASSED");
    else                     $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/uart_line_checker.sv ====
// watches the serial line, irq_o and the bus, compares against queued expectations
// frames are decoded at divisor_i clocks per bit, sampled mid-bit
// reads with a zero mask are polls and are not compared
`default_nettype none
`timescale 1ns/100ps

module uart_line_checker import axil_pkg::*, uart_pkg::*; (
  input wire             clk,
  input wire             rst_n,
  input wire             tx_i,
  input wire             irq_i,
  input wire [DIV_W-1:0] divisor_i,
  input axil_req_t       bus_i,
  input axil_rsp_t       bus_o
);

  logic [11:0]            frame_q[$];
  int                     len_q[$];
  logic [AXIL_DATA_W-1:0] rd_exp_q[$];
  logic [AXIL_DATA_W-1:0] rd_mask_q[$];
  int                     err_count = 0;

  task automatic add_frame(input logic [11:0] bits, input int len);
    frame_q.push_back(bits);
    len_q.push_back(len);
  endtask

  task automatic add_read(input logic [31:0] exp, input logic [31:0] mask);
    rd_exp_q.push_back(exp);
    rd_mask_q.push_back(mask);
  endtask

  task automatic check_irq(input logic exp, input string msg);
    if (irq_i !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0d ns: irq_o %b exp %b, %s", $time, irq_i, exp, msg);
    end
  endtask

  function automatic int pending();
    return frame_q.size() + rd_exp_q.size();
  endfunction

  // serial frame decoder
  always begin
    logic [11:0] got;
    logic [11:0] exp;
    int          len;
    @(posedge clk);
    if (rst_n && tx_i == 1'b0) begin
      got = '0;
      exp = '0;
      len = 10;
      if (frame_q.size() != 0) begin
        exp = frame_q.pop_front();
        len = len_q.pop_front();
      end else begin
        err_count++;
        $display("unexpected frame started on uart_tx_o at %0d ns", $time);
      end
      repeat (int'(divisor_i) / 2 - 1) @(posedge clk);  // middle of start bit
      got[0] = tx_i;
      for (int i = 1; i < len; i++) begin
        repeat (int'(divisor_i)) @(posedge clk);
        got[i] = tx_i;
      end
      for (int i = 0; i < len; i++) begin
        if (got[i] !== exp[i]) begin
          err_count++;
          $display("CHECK FAILED at %0d ns: frame bit %0d got %b exp %b (frame %h exp %h)",
                   $time, i, got[i], exp[i], got, exp);
          break;
        end
      end
    end
  end

  // bus responses
  always @(posedge clk) begin
    logic [31:0] exp;
    logic [31:0] mask;
    if (rst_n && bus_o.rvalid && bus_i.rready) begin
      if (bus_o.rresp != RESP_OKAY) begin
        err_count++;
        $display("CHECK FAILED at %0d ns: rresp %0d not OKAY", $time, bus_o.rresp);
      end
      if (rd_exp_q.size() == 0) begin
        err_count++;
        $display("read completed with no expected value queued at %0d ns", $time);
      end else begin
        exp  = rd_exp_q.pop_front();
        mask = rd_mask_q.pop_front();
        if ((bus_o.rdata & mask) !== (exp & mask)) begin
          err_count++;
          $display("CHECK FAILED at %0d ns: rdata %h exp %h", $time, bus_o.rdata, exp);
        end
      end
    end
    if (rst_n && bus_o.bvalid && bus_i.bready && bus_o.bresp != RESP_OKAY) begin
      err_count++;
      $display("CHECK FAILED at %0d ns: bresp %0d not OKAY", $time, bus_o.bresp);
    end
    // awready, wready and bvalid rise together, arready comes with rvalid
    if (rst_n && (bus_o.wready !== bus_o.awready || (bus_o.awready && !bus_o.bvalid))) begin
      err_count++;
      $display("CHECK FAILED at %0d ns: awready %b wready %b bvalid %b not raised together",
               $time, bus_o.awready, bus_o.wready, bus_o.bvalid);
    end
    if (rst_n && bus_o.arready && !bus_o.rvalid) begin
      err_count++;
      $display("CHECK FAILED at %0d ns: arready without rvalid", $time);
    end
    // the master raises its ready only while a response is owed
    if (rst_n && bus_i.bready && !bus_o.bvalid) begin
      err_count++;
      $display("CHECK FAILED at %0d ns: bvalid dropped before bready", $time);
    end
    if (rst_n && bus_i.rready && !bus_o.rvalid) begin
      err_count++;
      $display("CHECK FAILED at %0d ns: rvalid dropped before rready", $time);
    end
  end

endmodule

`default_nettype wire
